/* source/bpcu_params.svh */
`ifndef BPCU_PARAMS_SVH
`define BPCU_PARAMS_SVH

// major opcodes of the branch group, octal as in the instruction set manual
// unconditional branch, register target
`define BPCU_OPC_BRU 6'o46
// unconditional branch, immediate target
`define BPCU_OPC_BRUI 6'o56
// conditional branch, register target
`define BPCU_OPC_BCC 6'o47
// conditional branch, immediate target
`define BPCU_OPC_BCCI 6'o57

// word address every pc register starts from
`define BPCU_RESET_PC 30'h0000_0000

// forwarding source codes for register a
// register file copy
`define BPCU_SEL_REGA 2'd0
// alu result of the previous instruction
`define BPCU_SEL_ALU 2'd1
// i/o register
`define BPCU_SEL_IO 2'd2

`endif

/* source/bpcu_pkg.sv */
`default_nettype none

`include "bpcu_params.svh"

package bpcuPkg;

  // major opcode field, instruction bits 31..26
  typedef logic [5:0] opcode_t;

  // branch condition, taken from rd[2:0] of a conditional branch
  typedef enum logic [2:0] {
    condEq = 3'd0,
    condNe = 3'd1,
    condLt = 3'd2,
    condLe = 3'd3,
    condGt = 3'd4,
    condGe = 3'd5
  } condCode_t;

  // word address, byte address bits 31..2
  typedef logic [29:0] wordAddr_t;

  // forwarding source for register a, code 3 falls back to regA
  typedef enum logic [1:0] {
    selRegA = `BPCU_SEL_REGA,
    selAlu  = `BPCU_SEL_ALU,
    selIo   = `BPCU_SEL_IO
  } operandSel_t;

endpackage

`default_nettype wire

/* source/operandForward.sv */
`default_nettype none

module operandForward (
  input  logic                 gclk,
  input  logic                 arstN,
  input  logic                 dEn,
  input  bpcuPkg::operandSel_t operandSel,
  input  logic [31:0]          regA,
  input  logic [31:0]          aluResult,
  input  logic [31:0]          ioReg,
  output logic [31:0]          fwdA
);
  import bpcuPkg::*;

  // source picked for this decode slot
  logic [31:0] selData;

  // alu and i/o paths bypass the register file
  always_comb begin
    case (operandSel)
      selAlu:  selData = aluResult;
      selIo:   selData = ioReg;
      // selRegA and the unused code 3
      default: selData = regA;
    endcase
  end

  // operand register, held across decode stalls
  always_ff @(posedge gclk or negedge arstN) begin
    if (!arstN) begin
      fwdA <= 32'd0;
    end else if (dEn) begin
      fwdA <= selData;
    end
  end

endmodule

`default_nettype wire

/* source/branchDecode.sv */
`default_nettype none

`include "bpcu_params.svh"

module branchDecode (
  input  logic               gclk,
  input  logic               arstN,
  input  logic               dEn,
  input  logic               irq,
  input  logic               fSkip,
  input  logic [31:0]        instrX,
  output logic               isBranch,
  output logic               isUncond,
  output logic               delaySlot,
  output bpcuPkg::condCode_t cond
);
  import bpcuPkg::*;

  // instruction fields
  opcode_t    opcode;
  logic [4:0] rd;
  logic [4:0] ra;

  // decoded branch class
  logic isBru;
  logic isBcc;

  // values loaded on the next dEn edge
  logic      nextDelay;
  condCode_t nextCond;

  // opcode, rd, ra sit in the top 16 bits
  assign opcode = instrX[31:26];
  assign rd     = instrX[25:21];
  assign ra     = instrX[20:16];

  // unconditional group, an interrupt also lands here
  assign isBru = (opcode == `BPCU_OPC_BRU) ||
                 (opcode == `BPCU_OPC_BRUI) ||
                 irq;

  // conditional group, masked while an interrupt is pending
  assign isBcc = ((opcode == `BPCU_OPC_BCC) ||
                  (opcode == `BPCU_OPC_BCCI)) &&
                 !irq;

  // delay bit is ra[4] for bru, rd[4] for bcc
  // interrupt entry never has a delay slot
  assign nextDelay = (isBru && ra[4] && !irq) ||
                     (isBcc && rd[4]);

  // condition only matters for bcc, park it on eq otherwise
  assign nextCond = isBcc ? condCode_t'(rd[2:0]) : condEq;

  always_ff @(posedge gclk or negedge arstN) begin
    if (!arstN) begin
      isBranch  <= 1'b0;
      isUncond  <= 1'b0;
      delaySlot <= 1'b0;
      cond      <= condEq;
    end else if (fSkip) begin
      // squashed slot, back to no-branch regardless of dEn
      isBranch  <= 1'b0;
      isUncond  <= 1'b0;
      delaySlot <= 1'b0;
      cond      <= condEq;
    end else if (dEn) begin
      isBranch  <= isBru || isBcc;
      isUncond  <= isBru;
      delaySlot <= nextDelay;
      cond      <= nextCond;
    end
  end

endmodule

`default_nettype wire

/* source/branchResolve.sv */
`default_nettype none

module branchResolve (
  input  logic               isBranch,
  input  logic               isUncond,
  input  logic               delaySlot,
  input  bpcuPkg::condCode_t cond,
  input  logic [31:0]        fwdA,
  output logic               taken,
  output logic               dSkip,
  output logic               fSkip
);
  import bpcuPkg::*;

  // signed tests of the operand against zero
  logic isZero;
  logic isNeg;
  logic isLe;

  // selected condition result
  logic condHolds;

  assign isZero = (fwdA == 32'd0);
  // sign bit, two's complement
  assign isNeg  = fwdA[31];
  // le shared by le and gt
  assign isLe   = isZero || isNeg;

  always_comb begin
    case (cond)
      condEq:  condHolds = isZero;
      condNe:  condHolds = !isZero;
      condLt:  condHolds = isNeg;
      condLe:  condHolds = isLe;
      // gt as inverted le
      condGt:  condHolds = !isLe;
      condGe:  condHolds = !isNeg;
      // codes 6 and 7 never branch
      default: condHolds = 1'b0;
    endcase
  end

  // bru and interrupts ignore the operand
  assign taken = isBranch && (isUncond || condHolds);

  // squash rule
  // taken without delay slot kills the following instruction
  // delay-slot branch lets it through
  assign fSkip = taken && !delaySlot;

  // decode and fetch squash together
  assign dSkip = fSkip;

endmodule

`default_nettype wire

/* source/pcPipeline.sv */
`default_nettype none

`include "bpcu_params.svh"

module pcPipeline (
  input  logic               gclk,
  input  logic               arstN,
  input  logic               xEn,
  input  logic               taken,
  input  logic               fetchAdvance,
  input  logic               dSkip,
  input  bpcuPkg::wordAddr_t branchTarget,
  output bpcuPkg::wordAddr_t fetchAddr,
  output bpcuPkg::wordAddr_t prefetchPc,
  output bpcuPkg::wordAddr_t instrPc,
  output logic               xSkip
);
  import bpcuPkg::*;

  // sequential step, one word or none while fetch stalls
  wordAddr_t pcStep;

  assign pcStep = {29'd0, fetchAdvance};

  // branch target wins over the sequential path
  assign fetchAddr = taken ? branchTarget : (prefetchPc + pcStep);

  // two pc stages plus the execute squash flag
  always_ff @(posedge gclk or negedge arstN) begin
    if (!arstN) begin
      prefetchPc <= `BPCU_RESET_PC;
      instrPc    <= `BPCU_RESET_PC;
      xSkip      <= 1'b0;
    end else if (xEn) begin
      prefetchPc <= fetchAddr;
      // instruction pc trails prefetch by one xEn edge
      instrPc    <= prefetchPc;
      xSkip      <= dSkip;
    end
  end

endmodule

`default_nettype wire

/* source/bpcuTop.sv */
`default_nettype none

module bpcuTop (
  input  logic                 gclk,
  input  logic                 arstN,
  input  logic                 dEn,
  input  logic                 xEn,
  input  logic                 irq,
  input  logic                 fetchAdvance,
  input  logic [31:0]          instrX,
  input  logic [31:0]          regA,
  input  logic [31:0]          aluResult,
  input  logic [31:0]          ioReg,
  input  bpcuPkg::operandSel_t operandSel,
  output bpcuPkg::wordAddr_t   fetchAddr,
  output bpcuPkg::wordAddr_t   prefetchPc,
  output bpcuPkg::wordAddr_t   instrPc,
  output logic                 taken,
  output logic                 dSkip,
  output logic                 xSkip
);
  import bpcuPkg::*;

  // forwarded register a
  logic [31:0] fwdA;

  // decode controls
  logic      isBranch;
  logic      isUncond;
  logic      delaySlot;
  condCode_t cond;

  // fetch squash back into decode
  logic fSkip;

  // branch operand, captured with the decode slot
  operandForward uOperandForward (
    .gclk       (gclk),
    .arstN      (arstN),
    .dEn        (dEn),
    .operandSel (operandSel),
    .regA       (regA),
    .aluResult  (aluResult),
    .ioReg      (ioReg),
    .fwdA       (fwdA)
  );

  // branch class, condition and delay bit
  branchDecode uBranchDecode (
    .gclk      (gclk),
    .arstN     (arstN),
    .dEn       (dEn),
    .irq       (irq),
    .fSkip     (fSkip),
    .instrX    (instrX),
    .isBranch  (isBranch),
    .isUncond  (isUncond),
    .delaySlot (delaySlot),
    .cond      (cond)
  );

  // same-cycle condition evaluation
  branchResolve uBranchResolve (
    .isBranch  (isBranch),
    .isUncond  (isUncond),
    .delaySlot (delaySlot),
    .cond      (cond),
    .fwdA      (fwdA),
    .taken     (taken),
    .dSkip     (dSkip),
    .fSkip     (fSkip)
  );

  // target is the word part of the alu result
  pcPipeline uPcPipeline (
    .gclk         (gclk),
    .arstN        (arstN),
    .xEn          (xEn),
    .taken        (taken),
    .fetchAdvance (fetchAdvance),
    .dSkip        (dSkip),
    .branchTarget (aluResult[31:2]),
    .fetchAddr    (fetchAddr),
    .prefetchPc   (prefetchPc),
    .instrPc      (instrPc),
    .xSkip        (xSkip)
  );

endmodule

`default_nettype wire

/* sim/bpcu_checker.sv */
`default_nettype none

module bpcu_checker (
  input logic gclk,
  input logic arstN,
  input logic taken,
  input logic dSkip,
  input logic xSkip,
  input logic fSkip,
  input logic isBranch
);

  // a squash only ever comes from a taken branch
  assert property (@(posedge gclk) disable iff (!arstN) dSkip |-> taken)
    else $error("dSkip raised while taken is low");

  // execute squash flag is cleared by reset
  assert property (@(posedge gclk) !arstN |-> !xSkip)
    else $error("xSkip high during reset");

  // fetch squash sends decode back to no-branch
  assert property (@(posedge gclk) disable iff (!arstN) fSkip |=> !isBranch)
    else $error("decode still branching one cycle after fSkip");

endmodule

// internal decode and squash nets come from the top scope
bind bpcuTop bpcu_checker uChecker (
  .gclk     (gclk),
  .arstN    (arstN),
  .taken    (taken),
  .dSkip    (dSkip),
  .xSkip    (xSkip),
  .fSkip    (fSkip),
  .isBranch (isBranch)
);

`default_nettype wire

/* sim/tb_bpcu.sv */
`default_nettype none

`include "bpcu_params.svh"

module tb_bpcu;
  import bpcuPkg::*;

  // dut inputs
  logic        gclk;
  logic        arstN;
  logic        dEn;
  logic        xEn;
  logic        irq;
  logic        fetchAdvance;
  logic [31:0] instrX;
  logic [31:0] regA;
  logic [31:0] aluResult;
  logic [31:0] ioReg;
  operandSel_t operandSel;

  // dut outputs
  wordAddr_t fetchAddr;
  wordAddr_t prefetchPc;
  wordAddr_t instrPc;
  logic      taken;
  logic      dSkip;
  logic      xSkip;

  // case table read from the data file
  string       caseName [0:63];
  logic [31:0] caseData [0:63][0:10];
  int          numCases;

  // bookkeeping
  int          testErrors;
  int          passCount;
  int          failCount;
  int          cycles;
  int          cycleLimit = 1000;
  logic [31:0] rnd;
  // model of the prefetch pc after the last xEn pulse
  wordAddr_t   modelPf;

  bpcuTop i_dut (
    .gclk         (gclk),
    .arstN        (arstN),
    .dEn          (dEn),
    .xEn          (xEn),
    .irq          (irq),
    .fetchAdvance (fetchAdvance),
    .instrX       (instrX),
    .regA         (regA),
    .aluResult    (aluResult),
    .ioReg        (ioReg),
    .operandSel   (operandSel),
    .fetchAddr    (fetchAddr),
    .prefetchPc   (prefetchPc),
    .instrPc      (instrPc),
    .taken        (taken),
    .dSkip        (dSkip),
    .xSkip        (xSkip)
  );

  // 10 unit clock
  always #5 gclk = ~gclk;

  // run limit
  always @(posedge gclk) begin
    cycles = cycles + 1;
    if (cycles >= cycleLimit) begin
      $display("timeout: run did not finish within %0d cycles", cycleLimit);
      $display("Testbench failed");
      $finish;
    end
  end

  function automatic logic [31:0] nextRandom(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // signed compare against zero for each condition code
  function automatic logic condModel(input logic [2:0] c, input logic [31:0] a);
    logic signed [31:0] s;
    s = a;
    case (c)
      3'd0:    return s == 0;
      3'd1:    return s != 0;
      3'd2:    return s < 0;
      3'd3:    return s <= 0;
      3'd4:    return s > 0;
      3'd5:    return s >= 0;
      default: return 1'b0;
    endcase
  endfunction

  task automatic checkValue(input string testName, input string what,
                            input logic [31:0] expected, input logic [31:0] actual);
    if (expected !== actual) begin
      $display("FAILED %s %s expected %h actual %h", testName, what, expected, actual);
      testErrors = testErrors + 1;
    end
  endtask

  task automatic finishTest(input string testName);
    if (testErrors == 0) begin
      passCount = passCount + 1;
      $display("test %s: ok", testName);
    end else begin
      failCount = failCount + 1;
      $display("test %s: %0d mismatches", testName, testErrors);
    end
    testErrors = 0;
  endtask

  // one decode slot followed by one execute pulse
  task automatic runCase(input string testName, input logic [31:0] instr,
                         input logic [1:0] sel, input logic [31:0] a,
                         input logic [31:0] alu, input logic [31:0] io,
                         input logic irqIn, input logic adv, input logic expTaken,
                         input logic expSkip, input logic [31:0] expFetch,
                         input logic [31:0] expPf);
    @(posedge gclk);
    #1;
    instrX       = instr;
    operandSel   = operandSel_t'(sel);
    regA         = a;
    aluResult    = alu;
    ioReg        = io;
    irq          = irqIn;
    fetchAdvance = adv;
    dEn          = 1'b1;
    @(posedge gclk);
    #1;
    dEn = 1'b0;
    irq = 1'b0;
    xEn = 1'b1;
    @(negedge gclk);
    checkValue(testName, "taken", {31'd0, expTaken}, {31'd0, taken});
    checkValue(testName, "dSkip", {31'd0, expSkip}, {31'd0, dSkip});
    checkValue(testName, "fetchAddr", expFetch, {2'b00, fetchAddr});
    @(posedge gclk);
    #1;
    xEn = 1'b0;
    @(negedge gclk);
    checkValue(testName, "prefetchPc", expPf, {2'b00, prefetchPc});
    // xSkip carries the dSkip of the same slot
    checkValue(testName, "xSkip", {31'd0, expSkip}, {31'd0, xSkip});
    checkValue(testName, "instrPc", {2'b00, modelPf}, {2'b00, instrPc});
    modelPf = expPf[29:0];
    finishTest(testName);
  endtask

  // branch without delay slot with the next slot presented on the squash edge
  task automatic squashTest();
    wordAddr_t target;
    @(posedge gclk);
    #1;
    instrX       = {`BPCU_OPC_BRU, 26'd0};
    operandSel   = selRegA;
    regA         = 32'd0;
    aluResult    = 32'h0001_2000;
    fetchAdvance = 1'b1;
    dEn          = 1'b1;
    target       = aluResult[31:2];
    @(posedge gclk);
    #1;
    // beq on zero would be taken if decode accepted it
    instrX = {`BPCU_OPC_BCC, 26'd0};
    xEn    = 1'b1;
    @(negedge gclk);
    checkValue("squash", "taken", 32'd1, {31'd0, taken});
    checkValue("squash", "fetchAddr", {2'b00, target}, {2'b00, fetchAddr});
    @(posedge gclk);
    #1;
    dEn = 1'b0;
    xEn = 1'b0;
    @(negedge gclk);
    checkValue("squash", "taken after squash", 32'd0, {31'd0, taken});
    checkValue("squash", "xSkip", 32'd1, {31'd0, xSkip});
    checkValue("squash", "prefetchPc", {2'b00, target}, {2'b00, prefetchPc});
    checkValue("squash", "instrPc", {2'b00, modelPf}, {2'b00, instrPc});
    @(negedge gclk);
    checkValue("squash", "taken next cycle", 32'd0, {31'd0, taken});
    checkValue("squash", "fetchAddr seq", {2'b00, target + 30'd1}, {2'b00, fetchAddr});
    modelPf = target;
    finishTest("squash");
  endtask

  task automatic readCases();
    int    fd;
    int    n;
    string line;
    logic [31:0] v [0:10];
    string nm;
    fd = $fopen("sim/bpcu_cases.txt", "r");
    numCases = 0;
    if (fd == 0) begin
      $display("cannot open case file sim/bpcu_cases.txt");
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      // skip comment lines and blank lines
      if (n > 0 && line.getc(0) != 8'h23) begin
        n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h", nm,
                    v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9], v[10]);
        if (n == 12 && numCases < 64) begin
          caseName[numCases] = nm;
          for (int i = 0; i < 11; i++) begin
            caseData[numCases][i] = v[i];
          end
          numCases = numCases + 1;
        end
      end
    end
    $fclose(fd);
  endtask

  initial begin
    logic [2:0]  c;
    logic        dly;
    logic        tk;
    logic        adv;
    logic [31:0] a;
    logic [31:0] alu;
    logic [31:0] instr;
    wordAddr_t   fa;
    gclk         = 1'b0;
    arstN        = 1'b0;
    dEn          = 1'b0;
    xEn          = 1'b0;
    irq          = 1'b0;
    fetchAdvance = 1'b0;
    instrX       = 32'd0;
    regA         = 32'd0;
    aluResult    = 32'd0;
    ioReg        = 32'd0;
    operandSel   = selRegA;
    testErrors   = 0;
    passCount    = 0;
    failCount    = 0;
    cycles       = 0;
    modelPf      = `BPCU_RESET_PC;
    rnd          = 32'h6678_f303;
    readCases();
    cycleLimit = (numCases + 40) * 4 + 50;
    if (numCases == 0) begin
      $display("no cases were read from the case file");
      failCount = failCount + 1;
    end
    // reset for 4 cycles
    repeat (4) @(posedge gclk);
    #1;
    arstN = 1'b1;
    @(negedge gclk);
    checkValue("reset", "prefetchPc", 32'd0, {2'b00, prefetchPc});
    checkValue("reset", "instrPc", 32'd0, {2'b00, instrPc});
    checkValue("reset", "taken", 32'd0, {31'd0, taken});
    checkValue("reset", "xSkip", 32'd0, {31'd0, xSkip});
    finishTest("reset");
    // directed cases
    for (int i = 0; i < numCases; i++) begin
      runCase(caseName[i], caseData[i][0], caseData[i][1][1:0], caseData[i][2],
              caseData[i][3], caseData[i][4], caseData[i][5][0], caseData[i][6][0],
              caseData[i][7][0], caseData[i][8][0], caseData[i][9], caseData[i][10]);
    end
    squashTest();
    // random conditional branches
    for (int i = 0; i < 40; i++) begin
      rnd   = nextRandom(rnd);
      c     = 3'(rnd % 32'd6);
      dly   = rnd[8];
      adv   = rnd[9];
      // rd is delay bit, one spare bit, then the condition code
      instr = {(rnd[10] ? `BPCU_OPC_BCC : `BPCU_OPC_BCCI), dly, 1'b0, c, 21'd0};
      rnd   = nextRandom(rnd);
      // zero operand now and then so eq and le see their edge
      a     = (rnd[1:0] == 2'b00) ? 32'd0 : rnd;
      rnd   = nextRandom(rnd);
      alu   = rnd;
      tk    = condModel(c, a);
      fa    = tk ? alu[31:2] : (modelPf + {29'd0, adv});
      runCase($sformatf("rand%0d", i), instr, 2'd0, a, alu, 32'd0, 1'b0, adv,
              tk, tk && !dly, {2'b00, fa}, {2'b00, fa});
    end
    $display("%0d tests passed, %0d tests failed", passCount, failCount);
    if (failCount == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sim/bpcu_cases.txt */
# name instrX sel regA aluResult ioReg irq fetchAdvance taken dSkip fetchAddr prefetchPc
# all values hex, fetchAddr and prefetchPc are word addresses
seqAdv      00000000 0 00000000 00000100 00000000 0 1 0 0 00000001 00000001
seqAdv2     00000000 0 00000000 00000100 00000000 0 1 0 0 00000002 00000002
seqStall    00000000 0 00000000 00000100 00000000 0 0 0 0 00000002 00000002
beqZero     9C000000 0 00000000 00001000 00000000 0 1 1 1 00000400 00000400
beqPos      9C000000 0 00000005 00002000 00000000 0 1 0 0 00000401 00000401
bneZero     9C200000 0 00000000 00002000 00000000 0 1 0 0 00000402 00000402
bnePos      9C200000 0 00000007 00003000 00000000 0 1 1 1 00000C00 00000C00
bltNeg      9C400000 0 FFFFFFF0 00004000 00000000 0 1 1 1 00001000 00001000
bltZero     9C400000 0 00000000 00004000 00000000 0 1 0 0 00001001 00001001
bleZero     9C600000 0 00000000 00005000 00000000 0 1 1 1 00001400 00001400
blePos      9C600000 0 00000001 00005000 00000000 0 0 0 0 00001400 00001400
bgtPos      9C800000 0 00000010 00006000 00000000 0 1 1 1 00001800 00001800
bgtZero     9C800000 0 00000000 00006000 00000000 0 1 0 0 00001801 00001801
bgtNeg      9C800000 0 80000000 00006000 00000000 0 1 0 0 00001802 00001802
bgeZero     9CA00000 0 00000000 00007000 00000000 0 1 1 1 00001C00 00001C00
bgeNeg      9CA00000 0 FFFFFFFF 00007000 00000000 0 1 0 0 00001C01 00001C01
fwdRegA     9C000000 0 00000000 00008000 00000003 0 1 1 1 00002000 00002000
fwdAlu      9C000000 1 00000000 00008000 00000000 0 1 0 0 00002001 00002001
fwdIo       9C000000 2 00000009 00009000 00000000 0 1 1 1 00002400 00002400
fwdIoNz     9C000000 2 00000000 00009000 00000004 0 1 0 0 00002401 00002401
bruTaken    98000000 0 00000000 0000A000 00000000 0 1 1 1 00002800 00002800
bruiTaken   B8000000 0 00000000 0000B000 00000000 0 1 1 1 00002C00 00002C00
bruDelay    98100000 0 00000000 0000C000 00000000 0 1 1 0 00003000 00003000
bccDelay    9E000000 0 00000000 0000D000 00000000 0 1 1 0 00003400 00003400
bccDelayNot 9E000000 0 00000001 0000D000 00000000 0 1 0 0 00003401 00003401
irqAdd      00000000 0 00000000 0000E000 00000000 1 1 1 1 00003800 00003800
irqBcc      9C200000 0 00000000 0000F000 00000000 1 1 1 1 00003C00 00003C00
irqDelayBru 98100000 0 00000000 00010000 00000000 1 1 1 1 00004000 00004000
bcciTaken   BC000000 0 00000000 00011000 00000000 0 1 1 1 00004400 00004400
seqEnd      00000000 0 00000000 00011000 00000000 0 1 0 0 00004401 00004401

/* tb.f */
+incdir+source
source/bpcu_pkg.sv
source/operandForward.sv
source/branchDecode.sv
source/branchResolve.sv
source/pcPipeline.sv
source/bpcuTop.sv
sim/bpcu_checker.sv
sim/tb_bpcu.sv

/* run.sh */
#!/bin/sh
# build and run the bpcu testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tb_bpcu -o vtb_bpcu
status=$?
if [ $status -ne 0 ]; then
  echo "verilator compile failed with status $status"
  exit 1
fi

./obj_dir/vtb_bpcu > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^Testbench passed$" sim.log; then
  exit 0
fi
exit 1
